/* decode.sv */
`timescale 1ns/1ps

module decode import mips_pkg::*; (
	input logic clk,
	input logic reset,
	input logic [word_width-1:0] pc_next,
	input logic [word_width-1:0] instruction,
	input logic squash,
	input logic wb_valid,
	input logic [reg_addr_width-1:0] wb_reg,
	input logic [word_width-1:0] wb_data,
	output logic jump_taken,
	output logic [word_width-1:0] jump_target,
	output logic [word_width-1:0] ex_pc_next,
	output logic [word_width-1:0] ex_reg1,
	output logic [word_width-1:0] ex_reg2,
	output logic [word_width-1:0] ex_imm,
	output logic [reg_addr_width-1:0] ex_rs,
	output logic [reg_addr_width-1:0] ex_rt,
	output logic [reg_addr_width-1:0] ex_rd,
	output logic [reg_addr_width-1:0] ex_shamt,
	output alu_op_t ex_alu_op,
	output logic ex_alu_src_imm,
	output logic ex_reg_dst_rd,
	output logic ex_mem_read,
	output logic ex_mem_write,
	output logic ex_reg_write,
	output logic ex_branch
);

	logic [word_width-1:0] regs [2**reg_addr_width];
	logic [5:0] opcode;
	logic [5:0] funct;
	logic [reg_addr_width-1:0] rs;
	logic [reg_addr_width-1:0] rt;
	logic [word_width-1:0] reg1;
	logic [word_width-1:0] reg2;
	logic [word_width-1:0] imm_ext;
	alu_op_t alu_op;
	logic alu_src_imm;
	logic reg_dst_rd;
	logic mem_read;
	logic mem_write;
	logic reg_write;
	logic branch;

	assign opcode = instruction[31:26];
	assign funct = instruction[5:0];
	assign rs = instruction[25:21];
	assign rt = instruction[20:16];
	assign imm_ext = {{(word_width-16){instruction[15]}}, instruction[15:0]};

	//////////////////////////////////////////////////
	// Register file, writes land at the end of writeback
	always_ff @(posedge clk) begin
		if (wb_valid)
			regs[wb_reg] <= wb_data;
	end

	// Same-cycle write is bypassed to the read
	assign reg1 = (rs == '0) ? '0 : (wb_valid && wb_reg == rs) ? wb_data : regs[rs];
	assign reg2 = (rt == '0) ? '0 : (wb_valid && wb_reg == rt) ? wb_data : regs[rt];

	// Jump resolved here
	assign jump_taken = (opcode == op_j);
	assign jump_target = {pc_next[word_width-1:word_width-4], instruction[25:0], 2'b00};

	//////////////////////////////////////////////////
	always_comb begin
		alu_op = alu_add;
		alu_src_imm = 1'b0;
		reg_dst_rd = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		reg_write = 1'b0;
		branch = 1'b0;
		case (opcode)
			op_rtype: begin
				reg_dst_rd = 1'b1;
				reg_write = 1'b1;
				case (funct)
					funct_addu: alu_op = alu_add;
					funct_subu: alu_op = alu_sub;
					funct_and: alu_op = alu_and;
					funct_or: alu_op = alu_or;
					funct_slt: alu_op = alu_slt;
					funct_sll: alu_op = alu_sll;
					default: reg_write = 1'b0;
				endcase
			end
			op_addiu: begin
				alu_src_imm = 1'b1;
				reg_write = 1'b1;
			end
			op_lw: begin
				alu_src_imm = 1'b1;
				mem_read = 1'b1;
				reg_write = 1'b1;
			end
			op_sw: begin
				alu_src_imm = 1'b1;
				mem_write = 1'b1;
			end
			// Compare by subtraction
			op_beq: begin
				alu_op = alu_sub;
				branch = 1'b1;
			end
			default: ;
		endcase
	end

	// Decode to execute register
	always_ff @(posedge clk) begin
		if (reset || squash) begin
			ex_alu_op <= alu_add;
			ex_alu_src_imm <= 1'b0;
			ex_reg_dst_rd <= 1'b0;
			ex_mem_read <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_reg_write <= 1'b0;
			ex_branch <= 1'b0;
		end else begin
			ex_alu_op <= alu_op;
			ex_alu_src_imm <= alu_src_imm;
			ex_reg_dst_rd <= reg_dst_rd;
			ex_mem_read <= mem_read;
			ex_mem_write <= mem_write;
			ex_reg_write <= reg_write;
			ex_branch <= branch;
		end
	end

	always_ff @(posedge clk) begin
		ex_pc_next <= pc_next;
		ex_reg1 <= reg1;
		ex_reg2 <= reg2;
		ex_imm <= imm_ext;
		ex_rs <= rs;
		ex_rt <= rt;
		ex_rd <= instruction[15:11];
		ex_shamt <= instruction[10:6];
	end

	// Retirement never targets r0, even while a jump redirects
	assert property (@(posedge clk) disable iff (reset)
		!(jump_taken && wb_valid && wb_reg == '0));

endmodule

/* execute.sv */
`timescale 1ns/1ps

module execute import mips_pkg::*; (
	input logic clk,
	input logic reset,
	input logic squash,
	input logic [word_width-1:0] ex_pc_next,
	input logic [word_width-1:0] ex_reg1,
	input logic [word_width-1:0] ex_reg2,
	input logic [word_width-1:0] ex_imm,
	input logic [reg_addr_width-1:0] ex_rs,
	input logic [reg_addr_width-1:0] ex_rt,
	input logic [reg_addr_width-1:0] ex_rd,
	input logic [reg_addr_width-1:0] ex_shamt,
	input alu_op_t ex_alu_op,
	input logic ex_alu_src_imm,
	input logic ex_reg_dst_rd,
	input logic ex_mem_read,
	input logic ex_mem_write,
	input logic ex_reg_write,
	input logic ex_branch,
	input logic fwd_reg_write,
	input logic [reg_addr_width-1:0] fwd_dest,
	input logic [word_width-1:0] fwd_result,
	input logic wb_valid,
	input logic [reg_addr_width-1:0] wb_reg,
	input logic [word_width-1:0] wb_data,
	output logic [word_width-1:0] mem_result,
	output logic [word_width-1:0] mem_store_data,
	output logic [reg_addr_width-1:0] mem_dest,
	output logic [word_width-1:0] mem_branch_target,
	output logic mem_zero,
	output logic mem_mem_read,
	output logic mem_mem_write,
	output logic mem_reg_write,
	output logic mem_branch
);

	logic [word_width-1:0] op_a;
	logic [word_width-1:0] op_b_reg;
	logic [word_width-1:0] op_b;
	logic [word_width-1:0] alu_result;
	logic [reg_addr_width-1:0] dest;

	// Memory stage first, then writeback, then the register value
	function automatic logic [word_width-1:0] forward(
		input logic [reg_addr_width-1:0] src,
		input logic [word_width-1:0] file_value
	);
		if (fwd_reg_write && fwd_dest != '0 && fwd_dest == src)
			return fwd_result;
		if (wb_valid && wb_reg == src)
			return wb_data;
		return file_value;
	endfunction

	always_comb begin
		op_a = forward(ex_rs, ex_reg1);
		op_b_reg = forward(ex_rt, ex_reg2);
	end

	assign op_b = ex_alu_src_imm ? ex_imm : op_b_reg;
	assign dest = ex_reg_dst_rd ? ex_rd : ex_rt;

	//////////////////////////////////////////////////
	always_comb begin
		case (ex_alu_op)
			alu_add: alu_result = op_a + op_b;
			alu_sub: alu_result = op_a - op_b;
			alu_and: alu_result = op_a & op_b;
			alu_or: alu_result = op_a | op_b;
			alu_slt: alu_result = {{(word_width-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			alu_sll: alu_result = op_b << ex_shamt;
			default: alu_result = '0;
		endcase
	end

	// Execute to memory register
	always_ff @(posedge clk) begin
		if (reset || squash) begin
			mem_mem_read <= 1'b0;
			mem_mem_write <= 1'b0;
			mem_reg_write <= 1'b0;
			mem_branch <= 1'b0;
		end else begin
			mem_mem_read <= ex_mem_read;
			mem_mem_write <= ex_mem_write;
			mem_reg_write <= ex_reg_write;
			mem_branch <= ex_branch;
		end
	end

	always_ff @(posedge clk) begin
		mem_result <= alu_result;
		mem_store_data <= op_b_reg;
		mem_dest <= dest;
		mem_zero <= (alu_result == '0);
		// Word offset from pc+4
		mem_branch_target <= ex_pc_next + {ex_imm[word_width-3:0], 2'b00};
	end

	assert property (@(posedge clk) disable iff (reset)
		ex_alu_op inside {alu_add, alu_sub, alu_and, alu_or, alu_slt, alu_sll});

endmodule

/* instruction_fetch.sv */
`timescale 1ns/1ps

module instruction_fetch import mips_pkg::*; (
	input logic clk,
	input logic reset,
	input logic imem_we,
	input logic [imem_addr_width-1:0] imem_addr,
	input logic [word_width-1:0] imem_data,
	input logic jump_taken,
	input logic [word_width-1:0] jump_target,
	input logic branch_taken,
	input logic [word_width-1:0] branch_target,
	output logic [word_width-1:0] pc_next,
	output logic [word_width-1:0] instruction
);

	logic [word_width-1:0] imem [imem_depth];
	logic [word_width-1:0] pc;
	logic [word_width-1:0] pc_plus4;
	logic [word_width-1:0] pc_target;
	logic redirect;

	assign pc_plus4 = pc + word_width'(4);
	assign redirect = branch_taken || jump_taken;

	// Branch is older than the jump, so it wins
	always_comb begin
		if (branch_taken)
			pc_target = branch_target;
		else if (jump_taken)
			pc_target = jump_target;
		else
			pc_target = pc_plus4;
	end

	// Program load, one word per cycle
	always_ff @(posedge clk) begin
		if (imem_we)
			imem[imem_addr] <= imem_data;
	end

	always_ff @(posedge clk) begin
		if (reset)
			pc <= '0;
		else
			pc <= pc_target;
	end

	//////////////////////////////////////////////////
	// Fetch register, slot dropped on redirect
	always_ff @(posedge clk) begin
		if (reset || redirect)
			instruction <= nop_instruction;
		else
			instruction <= imem[pc[imem_addr_width+1:2]];
	end

	always_ff @(posedge clk) begin
		pc_next <= pc_plus4;
	end

endmodule

/* memory.sv */
`timescale 1ns/1ps

module memory import mips_pkg::*; (
	input logic clk,
	input logic reset,
	input logic [word_width-1:0] mem_result,
	input logic [word_width-1:0] mem_store_data,
	input logic [reg_addr_width-1:0] mem_dest,
	input logic [word_width-1:0] mem_branch_target,
	input logic mem_zero,
	input logic mem_mem_read,
	input logic mem_mem_write,
	input logic mem_reg_write,
	input logic mem_branch,
	output logic branch_taken,
	output logic [word_width-1:0] branch_target,
	output logic [word_width-1:0] read_data,
	output logic [word_width-1:0] wb_result,
	output logic [reg_addr_width-1:0] wb_reg,
	output logic wb_mem_to_reg,
	output logic wb_valid
);

	logic [word_width-1:0] dmem [dmem_depth];
	logic [dmem_addr_width-1:0] dmem_index;

	// Word addressed, low two bits ignored
	assign dmem_index = mem_result[dmem_addr_width+1:2];

	// beq resolves here
	assign branch_taken = mem_branch && mem_zero;
	assign branch_target = mem_branch_target;

	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (mem_mem_write)
			dmem[dmem_index] <= mem_store_data;
	end

	always_ff @(posedge clk) begin
		read_data <= dmem[dmem_index];
		wb_result <= mem_result;
		wb_reg <= mem_dest;
	end

	// Writes to r0 never retire
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_mem_to_reg <= 1'b0;
			wb_valid <= 1'b0;
		end else begin
			wb_mem_to_reg <= mem_mem_read;
			wb_valid <= mem_reg_write && mem_dest != '0;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		!(mem_mem_read && mem_mem_write));

endmodule

/* mips_pipeline.f */
mips_pkg.sv
instruction_fetch.sv
decode.sv
execute.sv
memory.sv
mips_pipeline.sv
tb_mips_pipeline.sv

/* mips_pipeline.sv */
`timescale 1ns/1ps

module mips_pipeline import mips_pkg::*; (
	input logic clk,
	input logic reset,
	input logic imem_we,
	input logic [imem_addr_width-1:0] imem_addr,
	input logic [word_width-1:0] imem_data,
	output logic wb_valid,
	output logic [reg_addr_width-1:0] wb_reg,
	output logic [word_width-1:0] wb_data
);

	// Fetch and redirect
	logic [word_width-1:0] pc_next, instruction;
	logic jump_taken, branch_taken;
	logic [word_width-1:0] jump_target, branch_target;

	// Decode to execute
	logic [word_width-1:0] ex_pc_next, ex_reg1, ex_reg2, ex_imm;
	logic [reg_addr_width-1:0] ex_rs, ex_rt, ex_rd, ex_shamt;
	alu_op_t ex_alu_op;
	logic ex_alu_src_imm, ex_reg_dst_rd, ex_mem_read, ex_mem_write, ex_reg_write, ex_branch;

	// Execute to memory
	logic [word_width-1:0] mem_result, mem_store_data, mem_branch_target;
	logic [reg_addr_width-1:0] mem_dest;
	logic mem_zero, mem_mem_read, mem_mem_write, mem_reg_write, mem_branch;

	// Memory to writeback
	logic [word_width-1:0] read_data, wb_result;
	logic wb_mem_to_reg;

	//////////////////////////////////////////////////
	// Writeback mux
	assign wb_data = wb_mem_to_reg ? read_data : wb_result;

	instruction_fetch u_instruction_fetch (
		.clk(clk),
		.reset(reset),
		.imem_we(imem_we),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.jump_taken(jump_taken),
		.jump_target(jump_target),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.pc_next(pc_next),
		.instruction(instruction)
	);

	decode u_decode (
		.clk(clk), .reset(reset),
		.pc_next(pc_next), .instruction(instruction), .squash(branch_taken),
		.wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
		.jump_taken(jump_taken), .jump_target(jump_target),
		.ex_pc_next(ex_pc_next), .ex_reg1(ex_reg1), .ex_reg2(ex_reg2), .ex_imm(ex_imm),
		.ex_rs(ex_rs), .ex_rt(ex_rt), .ex_rd(ex_rd), .ex_shamt(ex_shamt),
		.ex_alu_op(ex_alu_op), .ex_alu_src_imm(ex_alu_src_imm), .ex_reg_dst_rd(ex_reg_dst_rd),
		.ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
		.ex_reg_write(ex_reg_write), .ex_branch(ex_branch)
	);

	// Memory-stage values loop back for forwarding
	execute u_execute (
		.clk(clk), .reset(reset), .squash(branch_taken),
		.ex_pc_next(ex_pc_next), .ex_reg1(ex_reg1), .ex_reg2(ex_reg2), .ex_imm(ex_imm),
		.ex_rs(ex_rs), .ex_rt(ex_rt), .ex_rd(ex_rd), .ex_shamt(ex_shamt),
		.ex_alu_op(ex_alu_op), .ex_alu_src_imm(ex_alu_src_imm), .ex_reg_dst_rd(ex_reg_dst_rd),
		.ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
		.ex_reg_write(ex_reg_write), .ex_branch(ex_branch),
		.fwd_reg_write(mem_reg_write), .fwd_dest(mem_dest), .fwd_result(mem_result),
		.wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
		.mem_result(mem_result), .mem_store_data(mem_store_data), .mem_dest(mem_dest),
		.mem_branch_target(mem_branch_target), .mem_zero(mem_zero),
		.mem_mem_read(mem_mem_read), .mem_mem_write(mem_mem_write),
		.mem_reg_write(mem_reg_write), .mem_branch(mem_branch)
	);

	memory u_memory (
		.clk(clk), .reset(reset),
		.mem_result(mem_result), .mem_store_data(mem_store_data), .mem_dest(mem_dest),
		.mem_branch_target(mem_branch_target), .mem_zero(mem_zero),
		.mem_mem_read(mem_mem_read), .mem_mem_write(mem_mem_write),
		.mem_reg_write(mem_reg_write), .mem_branch(mem_branch),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.read_data(read_data), .wb_result(wb_result), .wb_reg(wb_reg),
		.wb_mem_to_reg(wb_mem_to_reg), .wb_valid(wb_valid)
	);

endmodule

/* mips_pkg.sv */
package mips_pkg;

	// Data path and register index widths
	localparam int word_width = 32;
	localparam int reg_addr_width = 5;

	// Memory sizes in words
	localparam int imem_depth = 64;
	localparam int dmem_depth = 64;
	localparam int imem_addr_width = $clog2(imem_depth);
	localparam int dmem_addr_width = $clog2(dmem_depth);

	//////////////////////////////////////////////////
	// Primary opcodes, bits 31 to 26
	localparam logic [5:0] op_rtype = 6'h00;
	localparam logic [5:0] op_j = 6'h02;
	localparam logic [5:0] op_beq = 6'h04;
	localparam logic [5:0] op_addiu = 6'h09;
	localparam logic [5:0] op_lw = 6'h23;
	localparam logic [5:0] op_sw = 6'h2b;

	// R-type function field
	localparam logic [5:0] funct_sll = 6'h00;
	localparam logic [5:0] funct_addu = 6'h21;
	localparam logic [5:0] funct_subu = 6'h23;
	localparam logic [5:0] funct_and = 6'h24;
	localparam logic [5:0] funct_or = 6'h25;
	localparam logic [5:0] funct_slt = 6'h2a;

	//////////////////////////////////////////////////
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,
		alu_sll
	} alu_op_t;

	// sll $0, $0, 0
	localparam logic [word_width-1:0] nop_instruction = '0;

endpackage

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -sv \
	--top-module tb_mips_pipeline \
	-f mips_pipeline.f \
	-Mdir obj_dir
./obj_dir/Vtb_mips_pipeline

/* tb_mips_pipeline.sv */
`timescale 1ns/1ps

module tb_mips_pipeline import mips_pkg::*; ();

	localparam int program_length = 40;
	localparam int last_index = program_length - 1;
	localparam int retire_timeout = 200;
	localparam int quiet_cycles = 40;
	localparam int step_limit = 1000;
	localparam logic [31:0] lfsr_seed = 32'hd7bc;
	localparam logic [31:0] lfsr_taps = 32'h80200003;

	logic clk;
	logic reset;
	logic imem_we;
	logic [imem_addr_width-1:0] imem_addr;
	logic [word_width-1:0] imem_data;
	logic wb_valid;
	logic [reg_addr_width-1:0] wb_reg;
	logic [word_width-1:0] wb_data;

	logic [31:0] lfsr_state;
	logic [31:0] code [program_length];
	logic [4:0] exp_reg [$];
	logic [31:0] exp_data [$];
	int expected_count;
	int retired;
	int taken_count;
	int not_taken_count;

	mips_pipeline UUT (
		.clk(clk),
		.reset(reset),
		.imem_we(imem_we),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.wb_valid(wb_valid),
		.wb_reg(wb_reg),
		.wb_data(wb_data)
	);

	always #2 clk = ~clk;

	//////////////////////////////////////////////////
	// Random source and instruction encoders
	function automatic logic next_bit();
		logic lsb;
		lsb = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (lsb)
			lfsr_state = lfsr_state ^ lfsr_taps;
		return lsb;
	endfunction

	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		int i;
		value = '0;
		for (i = 0; i < count; i++)
			value = {value[30:0], next_bit()};
		return value;
	endfunction

	// Registers 1 to 7, never the one given in avoid
	function automatic logic [4:0] random_reg(input logic [4:0] avoid);
		logic [4:0] r;
		r = 5'(random_bits(3));
		if (r == 5'd0)
			r = 5'd1;
		if (r == avoid)
			r = (r % 5'd7) + 5'd1;
		return r;
	endfunction

	function automatic logic [15:0] small_imm();
		logic [7:0] value;
		value = 8'(random_bits(8));
		return {{8{value[7]}}, value};
	endfunction

	// Byte address of one of the four data words in use
	function automatic logic [15:0] word_offset();
		return {12'd0, 2'(random_bits(2)), 2'b00};
	endfunction

	function automatic logic [31:0] encode_r(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] shamt, input logic [5:0] funct);
		return {op_rtype, rs, rt, rd, shamt, funct};
	endfunction

	function automatic logic [31:0] encode_i(input logic [5:0] opcode, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {opcode, rs, rt, imm};
	endfunction

	function automatic logic [31:0] encode_j(input int target);
		return {op_j, 26'(target)};
	endfunction

	//////////////////////////////////////////////////
	// Failure reporting
	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			fail_run($sformatf("MISMATCH %s: got 0x%08h, expected 0x%08h",
				name, actual, expected));
	endtask

	//////////////////////////////////////////////////
	// Program generator
	task automatic build_program();
		logic [4:0] load_dest;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [3:0] kind;
		int target;
		int idx;
		// Give every register and data word a known value first
		for (idx = 0; idx < 7; idx++)
			code[idx] = encode_i(op_addiu, 5'd0, 5'(idx + 1), small_imm());
		for (idx = 7; idx < 11; idx++)
			code[idx] = encode_i(op_sw, 5'd0, 5'(idx - 6), 16'((idx - 7) * 4));
		load_dest = 5'd0;
		for (idx = 11; idx < last_index; idx++) begin
			kind = 4'(random_bits(4));
			// No source may be the destination of a load just before
			rs = random_reg(load_dest);
			rt = random_reg(load_dest);
			rd = random_reg(5'd0);
			case (kind)
				4'd0, 4'd1: code[idx] = encode_r(rs, rt, rd, 5'd0, funct_addu);
				4'd2: code[idx] = encode_r(rs, rt, rd, 5'd0, funct_subu);
				4'd3: code[idx] = encode_r(rs, rt, rd, 5'd0, funct_and);
				4'd4: code[idx] = encode_r(rs, rt, rd, 5'd0, funct_or);
				4'd5: code[idx] = encode_r(rs, rt, rd, 5'd0, funct_slt);
				4'd6: code[idx] = encode_r(5'd0, rt, rd, 5'(random_bits(5)), funct_sll);
				4'd7, 4'd8: code[idx] = encode_i(op_addiu, rs, rd, small_imm());
				4'd9, 4'd10: code[idx] = encode_i(op_lw, 5'd0, rd, word_offset());
				4'd11, 4'd12: code[idx] = encode_i(op_sw, 5'd0, rt, word_offset());
				4'd13, 4'd14: begin
					// Half of them compare a register with itself
					if (next_bit())
						rt = rs;
					target = idx + 2 + int'(random_bits(2));
					if (target > last_index)
						target = last_index;
					code[idx] = encode_i(op_beq, rs, rt, 16'(target - idx - 1));
				end
				default: begin
					target = idx + 2 + int'(random_bits(1));
					if (target > last_index)
						target = last_index;
					code[idx] = encode_j(target);
				end
			endcase
			load_dest = (kind == 4'd9 || kind == 4'd10) ? rd : 5'd0;
		end
		code[last_index] = encode_j(last_index);
	endtask

	//////////////////////////////////////////////////
	// Instruction-level reference model
	task automatic run_model();
		logic [31:0] regs [32];
		logic [31:0] dmem [dmem_depth];
		logic written [dmem_depth];
		logic [31:0] word;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] result;
		logic [4:0] dest;
		logic writes;
		logic done;
		int index;
		int idx;
		int next_idx;
		int steps;
		for (idx = 0; idx < 32; idx++)
			regs[idx] = '0;
		for (idx = 0; idx < dmem_depth; idx++)
			written[idx] = 1'b0;
		idx = 0;
		steps = 0;
		done = 1'b0;
		while (!done) begin
			if (steps > step_limit)
				fail_run("reference model did not reach the final jump");
			steps++;
			word = code[idx];
			a = regs[word[25:21]];
			b = regs[word[20:16]];
			imm = {{16{word[15]}}, word[15:0]};
			writes = 1'b0;
			dest = 5'd0;
			result = '0;
			next_idx = idx + 1;
			case (word[31:26])
				op_rtype: begin
					writes = 1'b1;
					dest = word[15:11];
					case (word[5:0])
						funct_addu: result = a + b;
						funct_subu: result = a - b;
						funct_and: result = a & b;
						funct_or: result = a | b;
						funct_slt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						funct_sll: result = b << word[10:6];
						default: fail_run("reference model met an unknown function code");
					endcase
				end
				op_addiu: begin
					writes = 1'b1;
					dest = word[20:16];
					result = a + imm;
				end
				op_lw: begin
					index = int'(((a + imm) >> 2) % dmem_depth);
					if (!written[index])
						fail_run("program loads a data word that was never stored");
					writes = 1'b1;
					dest = word[20:16];
					result = dmem[index];
				end
				op_sw: begin
					index = int'(((a + imm) >> 2) % dmem_depth);
					dmem[index] = b;
					written[index] = 1'b1;
				end
				op_beq: begin
					if (a == b) begin
						next_idx = idx + 1 + int'($signed(imm));
						taken_count++;
					end else begin
						not_taken_count++;
					end
				end
				op_j: begin
					if (word[25:0] == 26'(idx))
						done = 1'b1;
					else
						next_idx = int'(word[25:0]);
				end
				default: fail_run("reference model met an unknown opcode");
			endcase
			if (writes && dest != 5'd0) begin
				regs[dest] = result;
				exp_reg.push_back(dest);
				exp_data.push_back(result);
			end
			idx = next_idx;
		end
	endtask

	//////////////////////////////////////////////////
	task automatic load_program();
		int idx;
		for (idx = 0; idx < program_length; idx++) begin
			@(negedge clk);
			imem_we = 1'b1;
			imem_addr = imem_addr_width'(idx);
			imem_data = code[idx];
		end
		@(negedge clk);
		imem_we = 1'b0;
	endtask

	// One expected write per wb_valid, in program order
	task automatic check_retirements();
		int waited;
		while (exp_reg.size() > 0) begin
			waited = 0;
			@(negedge clk);
			while (!wb_valid) begin
				waited++;
				if (waited > retire_timeout)
					fail_run($sformatf("timeout waiting for retirement %0d of %0d",
						retired + 1, expected_count));
				@(negedge clk);
			end
			check_value("wb_reg", 32'(wb_reg), 32'(exp_reg.pop_front()));
			check_value("wb_data", wb_data, exp_data.pop_front());
			retired++;
		end
	endtask

	// The final self-jump must not retire anything
	task automatic check_quiet();
		int cycle;
		for (cycle = 0; cycle < quiet_cycles; cycle++) begin
			@(negedge clk);
			if (wb_valid)
				fail_run($sformatf("register %0d written after the final jump", wb_reg));
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_data = '0;
		lfsr_state = lfsr_seed;
		retired = 0;
		taken_count = 0;
		not_taken_count = 0;
		build_program();
		run_model();
		expected_count = exp_reg.size();
		$display("model: %0d register writes, %0d taken beq, %0d not-taken beq",
			expected_count, taken_count, not_taken_count);
		load_program();
		repeat (2) @(negedge clk);
		reset = 1'b0;
		check_retirements();
		check_quiet();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule
